/* rtl/evrLinkPkg.sv */
/* Link-side definitions of the event receiver: receive word layout,
   event codes with a fixed meaning and the width of an action word */

package evrLinkPkg;

    // One byte of event code and one byte of distributed data per word
    typedef logic [7:0] evCodeT;
    typedef logic [7:0] dataByteT;

    // Receive word as delivered by the transceiver every evrRxClk cycle
    // charIsK[0] flags the event byte, charIsK[1] the data byte
    typedef struct packed {
        dataByteT   dataByte;
        evCodeT     evCode;
        logic [1:0] charIsK;
    } rxWordT;

    // Codes that carry the upcoming seconds value one bit at a time
    localparam evCodeT EV_SHIFT_ZERO = 8'h70;
    localparam evCodeT EV_SHIFT_ONE = 8'h71;

    // Once per second, applies the shifted-in value or advances the seconds
    localparam evCodeT EV_SECONDS_MARKER = 8'h7D;

    // Each event code maps to one action word in the lookup table
    localparam int ACTION_WIDTH = 8;
    typedef logic [ACTION_WIDTH-1:0] actionT;

    // Table index is the event code itself
    typedef logic [7:0] tableAddrT;

endpackage

/* rtl/evrTimePkg.sv */
/* Time-stamp definitions of the event receiver, shared by the tracker,
   the recorder and the top level */

package evrTimePkg;

    // Scaled down so that tick saturation is reachable in simulation
    localparam int SECONDS_WIDTH = 20;
    localparam int TICKS_WIDTH = 12;

    typedef logic [SECONDS_WIDTH-1:0] secondsT;
    typedef logic [TICKS_WIDTH-1:0] ticksT;

    // Seconds sit in the upper bits so the stamp compares as one number
    typedef struct packed {
        secondsT seconds;
        ticksT   ticks;
    } timestampT;

    // One recorded event: what the table said and when the event arrived
    // The stamp field is eventTime since time is a reserved word
    typedef struct packed {
        evrLinkPkg::actionT action;
        timestampT          eventTime;
    } eventRecordT;

endpackage

/* rtl/evrTimestampTracker.sv */
/* Time-stamp tracker. Collects the upcoming seconds from shift events,
   applies them on the seconds marker and counts ticks in between */

module evrTimestampTracker (
    input  logic                  evrRxClk,
    input  logic                  reset,
    input  evrLinkPkg::evCodeT    evCode,
    input  logic                  evCodeValid,
    output evrTimePkg::timestampT timestamp,
    output logic                  timestampValid,
    output logic                  ppsMarker
);
    import evrLinkPkg::*;
    import evrTimePkg::*;

    // Wide enough to count down from SECONDS_WIDTH-1 to zero
    typedef logic [$clog2(SECONDS_WIDTH)-1:0] bitCountT;

    // Upcoming seconds, shifted in most significant bit first
    secondsT  shiftReg;
    // Bits still missing before the shift register is full
    bitCountT bitsLeft;
    // Set by the last expected bit
    logic     enoughBits;
    // Set by any bit after the register was already full
    logic     tooManyBits;

    secondsT seconds;
    ticksT   ticks;

    logic isShift;
    logic isMarker;

    // Only data characters count as events
    assign isShift = evCodeValid
        && ((evCode == EV_SHIFT_ZERO) || (evCode == EV_SHIFT_ONE));
    assign isMarker = evCodeValid && (evCode == EV_SECONDS_MARKER);

    assign timestamp = '{seconds: seconds, ticks: ticks};

    //////////////////////////////
    // Seconds, ticks and validity
    //////////////////////////////

    always_ff @(posedge evrRxClk) begin
        if (reset) begin
            shiftReg <= '0;
            bitsLeft <= bitCountT'(SECONDS_WIDTH - 1);
            enoughBits <= 1'b0;
            tooManyBits <= 1'b0;
            seconds <= '0;
            ticks <= '0;
            timestampValid <= 1'b0;
            ppsMarker <= 1'b0;
        end else begin
            ppsMarker <= isMarker;
            if (isMarker) begin
                // A complete, exact set of bits replaces the seconds outright
                if (enoughBits && !tooManyBits) begin
                    seconds <= shiftReg;
                    timestampValid <= 1'b1;
                end else if (timestampValid) begin
                    // No usable value, so a valid stamp just moves on a second
                    seconds <= seconds + 1'b1;
                end
                // Start of a new second re-arms the bit collection
                ticks <= '0;
                bitsLeft <= bitCountT'(SECONDS_WIDTH - 1);
                enoughBits <= 1'b0;
                tooManyBits <= 1'b0;
            end else begin
                // Ticks stop at the top bit, the marker is overdue by then
                if (!ticks[TICKS_WIDTH-1]) begin
                    ticks <= ticks + 1'b1;
                end else begin
                    timestampValid <= 1'b0;
                end
                if (isShift) begin
                    // Code bit 0 tells a shift-one from a shift-zero
                    shiftReg <= {shiftReg[SECONDS_WIDTH-2:0], evCode[0]};
                    bitsLeft <= bitsLeft - 1'b1;
                    if (bitsLeft == '0) begin
                        enoughBits <= 1'b1;
                    end
                    if (enoughBits) begin
                        tooManyBits <= 1'b1;
                    end
                end
            end
        end
    end

    //////////////////////////////
    // Checks
    //////////////////////////////

    // Markers are a second apart on a real link
    ppsSinglePulse: assert property (
        @(posedge evrRxClk) disable iff (reset) ppsMarker |=> !ppsMarker);

    // Only a marker can make the stamp valid, never a tick or a shift
    validRisesOnMarker: assert property (
        @(posedge evrRxClk) disable iff (reset) $rose(timestampValid) |-> ppsMarker);

endmodule

/* rtl/evrActionMapper.sv */
/* Action mapper. Looks every event code up in a writable 256-entry table
   and presents the entry two cycles later, zero for K characters */

module evrActionMapper (
    input  logic                 evrRxClk,
    input  logic                 reset,
    input  evrLinkPkg::evCodeT   evCode,
    input  logic                 evCodeValid,
    input  logic                 tableWriteEnable,
    input  evrLinkPkg::tableAddrT tableAddress,
    input  evrLinkPkg::actionT   tableData,
    output evrLinkPkg::actionT   action
);
    import evrLinkPkg::*;

    // One action word per possible event code
    actionT actionTable [0:255];

    // First pipeline stage
    actionT tableQ;
    logic   tableQValid;

    //////////////////////////////
    // Table write port
    //////////////////////////////

    // A write lands at the edge, so only later words see the new entry
    always_ff @(posedge evrRxClk) begin
        if (tableWriteEnable) begin
            actionTable[tableAddress] <= tableData;
        end
    end

    //////////////////////////////
    // Lookup pipeline
    //////////////////////////////

    always_ff @(posedge evrRxClk) begin
        // The read itself is registered, a block RAM output stage
        tableQ <= actionTable[evCode];
        if (reset) begin
            tableQValid <= 1'b0;
            action <= '0;
        end else begin
            tableQValid <= evCodeValid;
            // K characters look something up too but must not act on it
            action <= tableQValid ? tableQ : '0;
        end
    end

    // Nothing may fire straight out of reset, whatever the table holds
    actionQuietAfterReset: assert property (
        @(posedge evrRxClk) $fell(reset) |=> (action == '0));

endmodule

/* rtl/evrEventRecorder.sv */
/* Event recorder. Pairs each non-zero action with the time stamp of its
   event and emits it as one record with a one-cycle strobe */

module evrEventRecorder (
    input  logic                    evrRxClk,
    input  logic                    reset,
    input  evrTimePkg::timestampT   timestamp,
    input  evrLinkPkg::actionT      action,
    output evrTimePkg::eventRecordT eventRecord,
    output logic                    recordStrobe
);
    import evrTimePkg::*;

    // The mapper is one cycle slower than the tracker
    // This copy lines the stamp up with the action of the same word
    timestampT timestampDly;

    always_ff @(posedge evrRxClk) begin
        timestampDly <= timestamp;
        // Record contents hold between events
        if (action != '0) begin
            eventRecord <= '{action: action, eventTime: timestampDly};
        end
        if (reset) begin
            recordStrobe <= 1'b0;
        end else begin
            recordStrobe <= (action != '0);
        end
    end

    //////////////////////////////
    // Checks
    //////////////////////////////

    // A strobe always comes with the record it announces
    strobeHasAction: assert property (
        @(posedge evrRxClk) disable iff (reset)
        recordStrobe |-> (eventRecord.action != '0));

endmodule

/* rtl/evrReceiver.sv */
/* Top level of the event receiver. Splits the receive word and connects
   the time-stamp tracker, the action mapper and the event recorder */

module evrReceiver (
    input  logic                    evrRxClk,
    input  logic                    reset,
    input  evrLinkPkg::rxWordT      rxWord,
    input  logic                    tableWriteEnable,
    input  evrLinkPkg::tableAddrT   tableAddress,
    input  evrLinkPkg::actionT      tableData,
    output evrTimePkg::timestampT   timestamp,
    output logic                    timestampValid,
    output logic                    ppsMarker,
    output evrLinkPkg::dataByteT    distributedDataBus,
    output evrLinkPkg::actionT      action,
    output evrTimePkg::eventRecordT eventRecord,
    output logic                    recordStrobe
);
    // The event byte is a real event only when it is not a K character
    logic evCodeValid;

    assign evCodeValid = !rxWord.charIsK[0];

    // Data byte passes through regardless of the K flags
    always_ff @(posedge evrRxClk) begin
        if (reset) begin
            distributedDataBus <= '0;
        end else begin
            distributedDataBus <= rxWord.dataByte;
        end
    end

    evrTimestampTracker u_evrTimestampTracker (
        .evrRxClk       (evrRxClk),
        .reset          (reset),
        .evCode         (rxWord.evCode),
        .evCodeValid    (evCodeValid),
        .timestamp      (timestamp),
        .timestampValid (timestampValid),
        .ppsMarker      (ppsMarker)
    );

    evrActionMapper u_evrActionMapper (
        .evrRxClk         (evrRxClk),
        .reset            (reset),
        .evCode           (rxWord.evCode),
        .evCodeValid      (evCodeValid),
        .tableWriteEnable (tableWriteEnable),
        .tableAddress     (tableAddress),
        .tableData        (tableData),
        .action           (action)
    );

    // Records take the tracker and mapper outputs as they leave the top
    evrEventRecorder u_evrEventRecorder (
        .evrRxClk     (evrRxClk),
        .reset        (reset),
        .timestamp    (timestamp),
        .action       (action),
        .eventRecord  (eventRecord),
        .recordStrobe (recordStrobe)
    );

endmodule

/* verif/evrReceiverTb.sv */
/* Testbench for the event receiver. Drives link words and table writes, runs a
   lock-step reference model and compares every DUT output on each falling edge */

module evrReceiverTb;
    import evrLinkPkg::*;
    import evrTimePkg::*;

    localparam int RESET_CYCLES = 10;
    localparam int TABLE_DEPTH = 256;
    // Four shift bursts of up to 21 bits, each bit possibly followed by an idle word
    localparam int SECONDS_TEST_CYCLES = 200;
    // Ticks saturate 2048 cycles after a marker, with some margin
    localparam int SATURATE_CYCLES = 2100;
    localparam int RANDOM_CYCLES = 3200;
    localparam int TIMEOUT_CYCLES = 2 * (RESET_CYCLES + TABLE_DEPTH + SECONDS_TEST_CYCLES
        + SATURATE_CYCLES + RANDOM_CYCLES);
    localparam logic [15:0] LFSR_SEED = 16'd36112;

    // Reference state of the tracker, counting shift bits instead of flagging them
    typedef struct packed {
        secondsT    shiftBits;
        logic [4:0] shiftCount;
        secondsT    seconds;
        ticksT      ticks;
        logic       valid;
        logic       pps;
    } trackerModelT;

    logic        evrRxClk;
    logic        reset;
    rxWordT      rxWord;
    logic        tableWriteEnable;
    tableAddrT   tableAddress;
    actionT      tableData;
    timestampT   timestamp;
    logic        timestampValid;
    logic        ppsMarker;
    dataByteT    distributedDataBus;
    actionT      action;
    eventRecordT eventRecord;
    logic        recordStrobe;

    logic [15:0]  lfsrState;
    int           cycleCount;
    int           strobeCount;
    trackerModelT mTrk;
    actionT       mTable [0:255];
    actionT       mStage1;
    actionT       mAction;
    timestampT    mTsDly;
    eventRecordT  mRecord;
    logic         mStrobe;
    logic         recordKnown;
    dataByteT     mData;
    secondsT      bits;
    secondsT      expSeconds;

    evrReceiver u_evrReceiver (
        .evrRxClk           (evrRxClk),
        .reset              (reset),
        .rxWord             (rxWord),
        .tableWriteEnable   (tableWriteEnable),
        .tableAddress       (tableAddress),
        .tableData          (tableData),
        .timestamp          (timestamp),
        .timestampValid     (timestampValid),
        .ppsMarker          (ppsMarker),
        .distributedDataBus (distributedDataBus),
        .action             (action),
        .eventRecord        (eventRecord),
        .recordStrobe       (recordStrobe)
    );

    initial begin
        evrRxClk = 1'b0;
        forever #10 evrRxClk = ~evrRxClk;
    end

    //////////////////////////////
    // Random numbers
    //////////////////////////////

    // Taps 16, 14, 13 and 11, one step per bit handed out
    function automatic logic [31:0] randomBits(input int n);
        logic [31:0] value;
        value = '0;
        for (int i = 0; i < n; i++) begin
            lfsrState = {lfsrState[14:0],
                lfsrState[15] ^ lfsrState[13] ^ lfsrState[12] ^ lfsrState[10]};
            value = {value[30:0], lfsrState[0]};
        end
        return value;
    endfunction

    // Any code except the ones the tracker reacts to
    function automatic evCodeT randomPlainCode();
        evCodeT code;
        code = evCodeT'(randomBits(8));
        while (code == EV_SHIFT_ZERO || code == EV_SHIFT_ONE || code == EV_SECONDS_MARKER) begin
            code = evCodeT'(randomBits(8));
        end
        return code;
    endfunction

    // About a quarter of the entries are zero, so some events record nothing
    function automatic actionT randomAction();
        if (randomBits(2) == 0) begin
            return '0;
        end else begin
            return actionT'(randomBits(ACTION_WIDTH));
        end
    endfunction

    //////////////////////////////
    // Reference model
    //////////////////////////////

    function automatic trackerModelT trackerNext(input trackerModelT cur, input evCodeT code,
                                                 input logic isEvent);
        trackerModelT nxt;
        nxt = cur;
        nxt.pps = isEvent && (code == EV_SECONDS_MARKER);
        if (nxt.pps) begin
            // Exactly a full set of bits loads, otherwise a valid stamp moves on a second
            if (cur.shiftCount == SECONDS_WIDTH) begin
                nxt.seconds = cur.shiftBits;
                nxt.valid = 1'b1;
            end else if (cur.valid) begin
                nxt.seconds = cur.seconds + secondsT'(1);
            end
            nxt.ticks = '0;
            nxt.shiftCount = '0;
        end else begin
            if (cur.ticks[TICKS_WIDTH-1]) begin
                nxt.valid = 1'b0;
            end else begin
                nxt.ticks = cur.ticks + ticksT'(1);
            end
            if (isEvent && (code == EV_SHIFT_ZERO || code == EV_SHIFT_ONE)) begin
                nxt.shiftBits = {cur.shiftBits[SECONDS_WIDTH-2:0], code[0]};
                // Saturate just past a full set, any surplus counts the same
                if (cur.shiftCount <= SECONDS_WIDTH) begin
                    nxt.shiftCount = cur.shiftCount + 5'd1;
                end
            end
        end
        return nxt;
    endfunction

    // Recorder first, then mapper, then tracker, so each stage reads last cycle's values
    always @(posedge evrRxClk) begin
        if (reset) begin
            mTrk = '0;
            mStage1 = '0;
            mAction = '0;
            mTsDly = '0;
            mStrobe = 1'b0;
            recordKnown = 1'b0;
            mData = '0;
        end else begin
            mStrobe = (mAction != '0);
            if (mAction != '0) begin
                mRecord = '{action: mAction, eventTime: mTsDly};
                recordKnown = 1'b1;
            end
            mTsDly = '{seconds: mTrk.seconds, ticks: mTrk.ticks};
            mAction = mStage1;
            mStage1 = rxWord.charIsK[0] ? '0 : mTable[rxWord.evCode];
            mTrk = trackerNext(mTrk, rxWord.evCode, !rxWord.charIsK[0]);
            mData = rxWord.dataByte;
        end
        // The write lands after this edge's lookup
        if (tableWriteEnable) begin
            mTable[tableAddress] = tableData;
        end
    end

    //////////////////////////////
    // Checking
    //////////////////////////////

    task automatic checkValue(input string name, input logic [63:0] expected,
                              input logic [63:0] actual);
        assert (actual === expected) else begin
            $display("FAILED %s expected %h actual %h", name, expected, actual);
            $display("TEST FAILED");
            $fatal(1, "Mismatch on %s", name);
        end
    endtask

    always @(negedge evrRxClk) begin
        if (!reset) begin
            checkValue("timestamp", 64'({mTrk.seconds, mTrk.ticks}), 64'(timestamp));
            checkValue("timestampValid", 64'(mTrk.valid), 64'(timestampValid));
            checkValue("ppsMarker", 64'(mTrk.pps), 64'(ppsMarker));
            checkValue("action", 64'(mAction), 64'(action));
            checkValue("distributedDataBus", 64'(mData), 64'(distributedDataBus));
            checkValue("recordStrobe", 64'(mStrobe), 64'(recordStrobe));
            // The record register has no reset, so it is compared once it was written
            if (recordKnown) begin
                checkValue("eventRecord", 64'(mRecord), 64'(eventRecord));
            end
            if (recordStrobe) begin
                strobeCount++;
            end
        end
    end

    initial begin
        cycleCount = 0;
        while (cycleCount < TIMEOUT_CYCLES) begin
            @(posedge evrRxClk);
            cycleCount++;
        end
        $display("Timeout: the run did not finish within %0d cycles", TIMEOUT_CYCLES);
        $display("TEST FAILED");
        $fatal(1, "Run stopped by the cycle limit");
    end

    //////////////////////////////
    // Stimulus
    //////////////////////////////

    // One link word per call, changed shortly after the rising edge
    task automatic driveWord(input evCodeT code, input logic codeIsK, input logic writeEnable,
                             input tableAddrT address);
        dataByteT dataByte;
        logic     dataIsK;
        actionT   entry;
        dataByte = dataByteT'(randomBits(8));
        dataIsK = randomBits(1) != 0;
        entry = randomAction();
        @(posedge evrRxClk);
        #2;
        rxWord = '{dataByte: dataByte, evCode: code, charIsK: {dataIsK, codeIsK}};
        tableWriteEnable = writeEnable;
        tableAddress = address;
        tableData = entry;
    endtask

    task automatic sendIdle();
        driveWord(randomPlainCode(), 1'b0, 1'b0, '0);
    endtask

    task automatic sendRandomWord();
        evCodeT    code;
        logic      codeIsK;
        logic      writeEnable;
        tableAddrT address;
        code = randomPlainCode();
        codeIsK = randomBits(2) == 0;
        writeEnable = randomBits(3) == 0;
        address = tableAddrT'(randomBits(8));
        driveWord(code, codeIsK, writeEnable, address);
    endtask

    // Shift bits in arrival order, the first one ends up most significant
    task automatic sendShiftBits(input int n, output secondsT shifted);
        logic bitValue;
        shifted = '0;
        for (int i = 0; i < n; i++) begin
            bitValue = randomBits(1) != 0;
            driveWord(bitValue ? EV_SHIFT_ONE : EV_SHIFT_ZERO, 1'b0, 1'b0, '0);
            shifted = {shifted[SECONDS_WIDTH-2:0], bitValue};
            if (randomBits(1) != 0) begin
                sendIdle();
            end
        end
    endtask

    // Marker, then one idle word, then the stamp is checked right after the marker's edge
    task automatic markerAndCheck(input secondsT expectedSeconds, input logic expectedValid);
        driveWord(EV_SECONDS_MARKER, 1'b0, 1'b0, '0);
        sendIdle();
        @(negedge evrRxClk);
        checkValue("timestamp.seconds", 64'(expectedSeconds), 64'(timestamp.seconds));
        checkValue("timestamp.ticks", 64'(0), 64'(timestamp.ticks));
        checkValue("timestampValid", 64'(expectedValid), 64'(timestampValid));
        checkValue("ppsMarker", 64'(1), 64'(ppsMarker));
    endtask

    initial begin
        rxWord = '{dataByte: 8'h00, evCode: 8'h00, charIsK: 2'b11};
        tableWriteEnable = 1'b0;
        tableAddress = '0;
        tableData = '0;
        reset = 1'b1;
        strobeCount = 0;
        lfsrState = LFSR_SEED;
        repeat (RESET_CYCLES) @(posedge evrRxClk);
        #2;
        reset = 1'b0;

        // Every entry gets written while only K characters are on the link
        for (int i = 0; i < TABLE_DEPTH; i++) begin
            driveWord(randomPlainCode(), 1'b1, 1'b1, tableAddrT'(i));
        end

        // Full set of bits loads the seconds
        sendShiftBits(SECONDS_WIDTH, bits);
        expSeconds = bits;
        markerAndCheck(expSeconds, 1'b1);

        // Short, long and missing sets advance a valid stamp by one
        sendShiftBits(SECONDS_WIDTH - 1, bits);
        expSeconds = expSeconds + secondsT'(1);
        markerAndCheck(expSeconds, 1'b1);
        sendShiftBits(SECONDS_WIDTH + 1, bits);
        expSeconds = expSeconds + secondsT'(1);
        markerAndCheck(expSeconds, 1'b1);
        expSeconds = expSeconds + secondsT'(1);
        markerAndCheck(expSeconds, 1'b1);

        // Overdue marker lets the ticks saturate and the stamp go invalid
        repeat (SATURATE_CYCLES) sendIdle();
        @(negedge evrRxClk);
        checkValue("timestampValid", 64'(0), 64'(timestampValid));
        checkValue("timestamp.ticks", 64'(ticksT'(1) << (TICKS_WIDTH - 1)),
            64'(timestamp.ticks));
        markerAndCheck(expSeconds, 1'b0);

        // Lookups, records and data bytes under random traffic and table writes
        repeat (RANDOM_CYCLES) sendRandomWord();
        repeat (4) sendIdle();

        assert (strobeCount > 0) begin
            $display("TEST PASSED");
            $finish;
        end else begin
            $display("No event record was produced during the random traffic");
            $display("TEST FAILED");
            $fatal(1, "No records seen");
        end
    end

endmodule

/* sim.f */
rtl/evrLinkPkg.sv
rtl/evrTimePkg.sv
rtl/evrTimestampTracker.sv
rtl/evrActionMapper.sv
rtl/evrEventRecorder.sv
rtl/evrReceiver.sv
verif/evrReceiverTb.sv

/* runSim.sh */
#!/bin/sh
# Builds the event receiver testbench with Verilator, runs it and checks the log

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --assert -Wno-fatal --top-module evrReceiverTb -f sim.f -o evrReceiverSim
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

./obj_dir/evrReceiverSim > "$LOG" 2>&1
runStatus=$?
cat "$LOG"

if grep -q "TEST FAILED" "$LOG"; then
    echo "Simulation reported a failure"
    exit 1
fi
if [ $runStatus -ne 0 ]; then
    echo "Simulation exited with status $runStatus"
    exit 1
fi
exit 0
